// ==== Makefile ====
# Verilator flow for the RV32I execute slice
# make lint | make sim | make clean

VERILATOR   ?= verilator
FILELIST    ?= rv32_exec.f
TOP         ?= tb_rv32_exec
RTL_TOP     ?= rv32_exec_core
OBJ_DIR     ?= obj_dir
LINT_FLAGS  ?=
BUILD_FLAGS ?= --binary --timing --assert -j 0
PASS_MSG    ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== alu.sv ====
// Combinational RV32I ALU
// Ten operations; shifts use the low five bits of B and the compares
// return 1 or 0
`default_nettype none

module alu (
  input  rv32i_pkg::alu_op_t op_i,
  input  rv32i_pkg::word_t   a_i,
  input  rv32i_pkg::word_t   b_i,
  output rv32i_pkg::word_t   result_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      rv32i_pkg::ALU_ADD:  result_o = a_i + b_i;
      rv32i_pkg::ALU_SUB:  result_o = a_i - b_i;
      rv32i_pkg::ALU_SLL:  result_o = a_i << shamt;
      rv32i_pkg::ALU_SRL:  result_o = a_i >> shamt;
      rv32i_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      rv32i_pkg::ALU_AND:  result_o = a_i & b_i;
      rv32i_pkg::ALU_OR:   result_o = a_i | b_i;
      rv32i_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      rv32i_pkg::ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      rv32i_pkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
      default:             result_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== branch_unit.sv ====
// Branch and jump resolution
// Compares the two source registers for a branch and forms the redirect
// target for branches, JAL and JALR, along with the link address
`default_nettype none

module branch_unit (
  input  logic                branch_i,
  input  logic                jump_i,
  input  logic                j_sel_i,
  input  rv32i_pkg::branch_t  branch_type_i,
  input  rv32i_pkg::word_t    rs1_data_i,
  input  rv32i_pkg::word_t    rs2_data_i,
  input  rv32i_pkg::word_t    pc_i,
  input  rv32i_pkg::word_t    imm_sb_i,
  input  rv32i_pkg::word_t    imm_uj_i,
  input  rv32i_pkg::word_t    jalr_sum_i,
  output logic                taken_o,
  output rv32i_pkg::word_t    target_o,
  output rv32i_pkg::word_t    link_o
);

  logic cond;

  always_comb begin
    case (branch_type_i)
      rv32i_pkg::BEQ:  cond = (rs1_data_i == rs2_data_i);
      rv32i_pkg::BNE:  cond = (rs1_data_i != rs2_data_i);
      rv32i_pkg::BLT:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
      rv32i_pkg::BGE:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      rv32i_pkg::BLTU: cond = (rs1_data_i < rs2_data_i);
      rv32i_pkg::BGEU: cond = (rs1_data_i >= rs2_data_i);
      default:         cond = 1'b0;
    endcase
  end

  assign taken_o = (branch_i && cond) || jump_i;

  // JALR clears bit zero of rs1 plus offset
  always_comb begin
    if (!jump_i) begin
      target_o = pc_i + imm_sb_i;
    end else if (j_sel_i) begin
      target_o = pc_i + imm_uj_i;
    end else begin
      target_o = {jalr_sum_i[31:1], 1'b0};
    end
  end

  assign link_o = pc_i + 32'd4;

endmodule

`default_nettype wire

// ==== control_unit.sv ====
// Combinational RV32I instruction decoder
// Produces register indices, all immediate formats, operand and writeback
// selects, ALU operation, memory enables and byte lanes. The byte offset
// comes back from the ALU sum to place the lanes of a load or store
`default_nettype none

module control_unit (
  input  rv32i_pkg::instr_t instr_i,
  input  logic [1:0]        byte_offset_i,
  output rv32i_pkg::ctrl_t  ctrl_o
);

  rv32i_pkg::opcode_t   opcode;
  rv32i_pkg::arith_f3_t f3;
  rv32i_pkg::load_t     width;

  assign opcode = rv32i_pkg::opcode_t'(instr_i[6:0]);
  assign f3     = rv32i_pkg::arith_f3_t'(instr_i[14:12]);
  assign width  = rv32i_pkg::load_t'(instr_i[14:12]);

  always_comb begin
    // Fields
    ctrl_o.rs1 = instr_i[19:15];
    ctrl_o.rs2 = instr_i[24:20];
    ctrl_o.rd  = instr_i[11:7];

    // Immediates, all sign extended except U
    ctrl_o.imm_I  = {{20{instr_i[31]}}, instr_i[31:20]};
    ctrl_o.imm_S  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    ctrl_o.imm_SB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
    ctrl_o.imm_UJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
    ctrl_o.imm_U  = {instr_i[31:12], 12'b0};

    ctrl_o.load_type   = width;
    ctrl_o.branch_type = rv32i_pkg::branch_t'(instr_i[14:12]);

    // Memory and control flow
    ctrl_o.dren   = (opcode == rv32i_pkg::LOAD);
    ctrl_o.dwen   = (opcode == rv32i_pkg::STORE);
    ctrl_o.branch = (opcode == rv32i_pkg::BRANCH);
    ctrl_o.jump   = (opcode == rv32i_pkg::JAL) || (opcode == rv32i_pkg::JALR);
    ctrl_o.j_sel  = (opcode == rv32i_pkg::JAL);
    ctrl_o.halt   = (instr_i == rv32i_pkg::HALT_INSTR);

    // Operand A is the PC only for AUIPC
    ctrl_o.alu_a_sel = (opcode == rv32i_pkg::AUIPC) ? rv32i_pkg::A_PC : rv32i_pkg::A_RS1;

    // Operand B; loads and JALR take the I immediate
    case (opcode)
      rv32i_pkg::REGREG: ctrl_o.alu_b_sel = rv32i_pkg::B_RS2;
      rv32i_pkg::BRANCH: ctrl_o.alu_b_sel = rv32i_pkg::B_RS2;
      rv32i_pkg::STORE:  ctrl_o.alu_b_sel = rv32i_pkg::B_IMM_S;
      rv32i_pkg::AUIPC:  ctrl_o.alu_b_sel = rv32i_pkg::B_IMM_U;
      default:           ctrl_o.alu_b_sel = rv32i_pkg::B_IMM_I;
    endcase

    // Writeback source and enable
    ctrl_o.wen = 1'b1;
    case (opcode)
      rv32i_pkg::LOAD:   ctrl_o.w_sel = rv32i_pkg::W_LOAD;
      rv32i_pkg::JAL,
      rv32i_pkg::JALR:   ctrl_o.w_sel = rv32i_pkg::W_LINK;
      rv32i_pkg::LUI:    ctrl_o.w_sel = rv32i_pkg::W_IMM_U;
      rv32i_pkg::IMMED,
      rv32i_pkg::REGREG,
      rv32i_pkg::AUIPC:  ctrl_o.w_sel = rv32i_pkg::W_ALU;
      default: begin
        // Stores, branches and anything unknown write nothing
        ctrl_o.w_sel = rv32i_pkg::W_ALU;
        ctrl_o.wen   = 1'b0;
      end
    endcase

    // ALU operation, address arithmetic defaults to ADD
    ctrl_o.alu_op = rv32i_pkg::ALU_ADD;
    if (opcode == rv32i_pkg::REGREG || opcode == rv32i_pkg::IMMED) begin
      case (f3)
        rv32i_pkg::F3_ADD: begin
          // SUB exists only in register form
          if (opcode == rv32i_pkg::REGREG && instr_i[30]) begin
            ctrl_o.alu_op = rv32i_pkg::ALU_SUB;
          end
        end
        rv32i_pkg::F3_SLL:  ctrl_o.alu_op = rv32i_pkg::ALU_SLL;
        rv32i_pkg::F3_SLT:  ctrl_o.alu_op = rv32i_pkg::ALU_SLT;
        rv32i_pkg::F3_SLTU: ctrl_o.alu_op = rv32i_pkg::ALU_SLTU;
        rv32i_pkg::F3_XOR:  ctrl_o.alu_op = rv32i_pkg::ALU_XOR;
        rv32i_pkg::F3_SR: begin
          // Bit 30 picks arithmetic shift
          ctrl_o.alu_op = instr_i[30] ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
        end
        rv32i_pkg::F3_OR:   ctrl_o.alu_op = rv32i_pkg::ALU_OR;
        rv32i_pkg::F3_AND:  ctrl_o.alu_op = rv32i_pkg::ALU_AND;
        default:            ctrl_o.alu_op = rv32i_pkg::ALU_ADD;
      endcase
    end

    // Byte lanes, empty mask when misaligned
    case (width)
      rv32i_pkg::LB,
      rv32i_pkg::LBU: ctrl_o.byte_en = 4'b0001 << byte_offset_i;
      rv32i_pkg::LH,
      rv32i_pkg::LHU: ctrl_o.byte_en = byte_offset_i[0] ? 4'b0000 : 4'b0011 << byte_offset_i;
      rv32i_pkg::LW:  ctrl_o.byte_en = (byte_offset_i == 2'b00) ? 4'b1111 : 4'b0000;
      default:        ctrl_o.byte_en = 4'b0000;
    endcase
  end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
// Word-organized data memory with byte lanes
// Stores replicate the byte or halfword across the word and write the
// enabled lanes. Loads read combinationally and return the addressed
// lane already sign or zero extended
`default_nettype none

module data_mem #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                CLK,
  input  logic                we_i,
  input  rv32i_pkg::word_t    addr_i,
  input  rv32i_pkg::byte_en_t byte_en_i,
  input  rv32i_pkg::word_t    wdata_i,
  input  rv32i_pkg::load_t    load_type_i,
  output rv32i_pkg::word_t    rdata_o
);

  localparam int AW = $clog2(DMEM_WORDS);

  rv32i_pkg::word_t mem [DMEM_WORDS];
  logic [AW-1:0]    idx;
  rv32i_pkg::word_t wdata_rep;
  rv32i_pkg::word_t lane;

  // Upper address bits wrap around the depth
  assign idx = addr_i[AW+1:2];

  always_comb begin
    case (load_type_i)
      rv32i_pkg::LB,
      rv32i_pkg::LBU: wdata_rep = {4{wdata_i[7:0]}};
      rv32i_pkg::LH,
      rv32i_pkg::LHU: wdata_rep = {2{wdata_i[15:0]}};
      default:        wdata_rep = wdata_i;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (we_i) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en_i[i]) begin
          mem[idx][i*8 +: 8] <= wdata_rep[i*8 +: 8];
        end
      end
    end
  end

  // Addressed byte or halfword moved down to bit 0
  assign lane = mem[idx] >> {addr_i[1:0], 3'b000};

  always_comb begin
    case (load_type_i)
      rv32i_pkg::LB:  rdata_o = {{24{lane[7]}}, lane[7:0]};
      rv32i_pkg::LBU: rdata_o = {24'b0, lane[7:0]};
      rv32i_pkg::LH:  rdata_o = {{16{lane[15]}}, lane[15:0]};
      rv32i_pkg::LHU: rdata_o = {16'b0, lane[15:0]};
      default:        rdata_o = lane;
    endcase
  end

  a_store_lanes: assert property (@(posedge CLK) we_i |-> (byte_en_i != '0))
    else $error("store with an empty lane mask at %h", addr_i);

endmodule

`default_nettype wire

// ==== rv32_exec.f ====
+incdir+.
rv32i_pkg.sv
control_unit.sv
rv32i_reg_file.sv
alu.sv
branch_unit.sv
data_mem.sv
rv32_exec_core.sv
tb_rv32_exec.sv

// ==== rv32_exec_core.sv ====
// Top of the RV32I execute slice
// Each strobe on instr_valid_i decodes, executes and commits one
// instruction; writeback, redirect and halt appear one cycle later.
// Strobes are ignored once halted, until reset
`default_nettype none

module rv32_exec_core #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                 CLK,
  input  logic                 reset_i,
  input  logic                 instr_valid_i,
  input  rv32i_pkg::instr_t    instr_i,
  input  rv32i_pkg::word_t     pc_i,
  output rv32i_pkg::wb_t       wb_o,
  output rv32i_pkg::redirect_t redirect_o,
  output logic                 halt_o
);

  rv32i_pkg::ctrl_t ctrl;
  rv32i_pkg::word_t rs1_data;
  rv32i_pkg::word_t rs2_data;
  rv32i_pkg::word_t alu_a;
  rv32i_pkg::word_t alu_b;
  rv32i_pkg::word_t alu_result;
  rv32i_pkg::word_t load_data;
  rv32i_pkg::word_t wb_data;
  rv32i_pkg::word_t target;
  rv32i_pkg::word_t link;
  logic             taken;
  logic             commit;

  // Only a strobe while running changes any state
  assign commit = instr_valid_i && !halt_o;

  control_unit control_unit_i (
    .instr_i       (instr_i),
    .byte_offset_i (alu_result[1:0]),
    .ctrl_o        (ctrl)
  );

  rv32i_reg_file rv32i_reg_file_i (
    .CLK      (CLK),
    .reset_i  (reset_i),
    .we_i     (commit && ctrl.wen),
    .rd_i     (ctrl.rd),
    .rs1_i    (ctrl.rs1),
    .rs2_i    (ctrl.rs2),
    .wdata_i  (wb_data),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  assign alu_a = (ctrl.alu_a_sel == rv32i_pkg::A_PC) ? pc_i : rs1_data;

  always_comb begin
    case (ctrl.alu_b_sel)
      rv32i_pkg::B_IMM_I: alu_b = ctrl.imm_I;
      rv32i_pkg::B_IMM_S: alu_b = ctrl.imm_S;
      rv32i_pkg::B_IMM_U: alu_b = ctrl.imm_U;
      default:            alu_b = rs2_data;
    endcase
  end

  alu alu_i (
    .op_i     (ctrl.alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  branch_unit branch_unit_i (
    .branch_i      (ctrl.branch),
    .jump_i        (ctrl.jump),
    .j_sel_i       (ctrl.j_sel),
    .branch_type_i (ctrl.branch_type),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .pc_i          (pc_i),
    .imm_sb_i      (ctrl.imm_SB),
    .imm_uj_i      (ctrl.imm_UJ),
    .jalr_sum_i    (alu_result),
    .taken_o       (taken),
    .target_o      (target),
    .link_o        (link)
  );

  // ALU sum is the data address
  data_mem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) data_mem_i (
    .CLK         (CLK),
    .we_i        (commit && ctrl.dwen),
    .addr_i      (alu_result),
    .byte_en_i   (ctrl.byte_en),
    .wdata_i     (rs2_data),
    .load_type_i (ctrl.load_type),
    .rdata_o     (load_data)
  );

  always_comb begin
    case (ctrl.w_sel)
      rv32i_pkg::W_LOAD:  wb_data = ctrl.dren ? load_data : '0;
      rv32i_pkg::W_LINK:  wb_data = link;
      rv32i_pkg::W_IMM_U: wb_data = ctrl.imm_U;
      default:            wb_data = alu_result;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      wb_o       <= '0;
      redirect_o <= '0;
      halt_o     <= 1'b0;
    end else begin
      // rd zero is still reported
      wb_o.valid        <= commit && ctrl.wen;
      wb_o.rd           <= ctrl.rd;
      wb_o.data         <= wb_data;
      redirect_o.valid  <= commit && taken;
      redirect_o.target <= target;
      if (commit && ctrl.halt) begin
        halt_o <= 1'b1;
      end
    end
  end

  a_halt_sticky: assert property (@(posedge CLK) $fell(halt_o) |-> $past(reset_i))
    else $error("halt_o dropped without reset");

endmodule

`default_nettype wire

// ==== rv32i_pkg.sv ====
// Shared types for the RV32I execute slice
// Holds the field widths, opcode and funct3 encodings, ALU operations
// and the structs passed from the decoder to the datapath and outputs
`default_nettype none

package rv32i_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;

  // Fixed halt encoding, a SYSTEM opcode the slice does not otherwise decode
  localparam instr_t HALT_INSTR = 32'h7800_d073;

  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_t;

  // funct3 of IMMED and REGREG
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } arith_f3_t;

  // Stores use the same codes for SB, SH and SW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  typedef enum logic {
    A_RS1,
    A_PC
  } alu_a_sel_t;

  typedef enum logic [1:0] {
    B_RS2,
    B_IMM_I,
    B_IMM_S,
    B_IMM_U
  } alu_b_sel_t;

  typedef enum logic [1:0] {
    W_LOAD,
    W_LINK,
    W_IMM_U,
    W_ALU
  } w_sel_t;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm_I;
    word_t      imm_S;
    word_t      imm_SB;
    word_t      imm_UJ;
    word_t      imm_U;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    alu_op_t    alu_op;
    w_sel_t     w_sel;
    logic       wen;
    logic       dren;
    logic       dwen;
    byte_en_t   byte_en;
    load_t      load_type;
    logic       branch;
    branch_t    branch_type;
    logic       jump;
    logic       j_sel;      // 1 for JAL, 0 for JALR
    logic       halt;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

endpackage

`default_nettype wire

// ==== rv32i_reg_file.sv ====
// RV32I integer register file
// Writable registers x1 to x31 with two combinational read ports and one
// synchronous write port. x0 always reads as zero
`default_nettype none

module rv32i_reg_file (
  input  logic                CLK,
  input  logic                reset_i,
  input  logic                we_i,
  input  rv32i_pkg::reg_idx_t rd_i,
  input  rv32i_pkg::reg_idx_t rs1_i,
  input  rv32i_pkg::reg_idx_t rs2_i,
  input  rv32i_pkg::word_t    wdata_i,
  output rv32i_pkg::word_t    rdata1_o,
  output rv32i_pkg::word_t    rdata2_o
);

  // Entry zero is cleared by reset and skipped by every write
  rv32i_pkg::word_t regs [32];

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

  // Index zero must read zero on both ports
  a_x0_zero: assert property (@(posedge CLK) disable iff (reset_i)
    (rs1_i != '0 || rdata1_o == '0) && (rs2_i != '0 || rdata2_o == '0))
    else $error("x0 read back a nonzero value");

endmodule

`default_nettype wire

// ==== rv32_ref_model.svh ====
// Reference model of the RV32I execute slice, included in the testbench
// Mirrors the registers and data memory and predicts the writeback,
// redirect and halt state that follow each strobe.
// Expects DMEM_WORDS to be declared before the include
`ifndef RV32_REF_MODEL_SVH
`define RV32_REF_MODEL_SVH

typedef struct packed {
  rv32i_pkg::wb_t       wb;
  rv32i_pkg::redirect_t redir;
  logic                 halt;
} result_t;

localparam int MEM_AW = $clog2(DMEM_WORDS);

rv32i_pkg::word_t m_regs [32];
rv32i_pkg::word_t m_mem [DMEM_WORDS];
logic             m_halted;

// Memory mirror is left alone, like the real memory
function automatic void model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_halted = 1'b0;
endfunction

function automatic logic signed_less(rv32i_pkg::word_t a, rv32i_pkg::word_t b);
  // Differing signs decide on their own
  return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic rv32i_pkg::word_t arith(logic [2:0] f3, logic alt, logic is_reg,
                                           rv32i_pkg::word_t a, rv32i_pkg::word_t b);
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'b000:  return (is_reg && alt) ? a - b : a + b;
    3'b001:  return a << sh;
    3'b010:  return {31'b0, signed_less(a, b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    // Arithmetic shift fills the vacated top bits with ones
    3'b101:  return (alt && a[31]) ? ((a >> sh) | ~(32'hffff_ffff >> sh)) : (a >> sh);
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_cond(logic [2:0] f3, rv32i_pkg::word_t a, rv32i_pkg::word_t b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return signed_less(a, b);
    3'b101:  return !signed_less(a, b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic rv32i_pkg::word_t load_value(logic [2:0] f3, rv32i_pkg::word_t w,
                                                logic [1:0] off);
  logic [7:0]  by;
  logic [15:0] hw;
  by = w[{off, 3'b000} +: 8];
  hw = w[{off[1], 4'b0000} +: 16];
  case (f3)
    3'b000:  return {{24{by[7]}}, by};
    3'b100:  return {24'b0, by};
    3'b001:  return {{16{hw[15]}}, hw};
    3'b101:  return {16'b0, hw};
    default: return w;
  endcase
endfunction

function automatic rv32i_pkg::word_t store_value(logic [2:0] f3, rv32i_pkg::word_t old,
                                                 rv32i_pkg::word_t d, logic [1:0] off);
  rv32i_pkg::word_t w;
  w = old;
  case (f3)
    3'b000:  w[{off, 3'b000} +: 8] = d[7:0];
    3'b001:  w[{off[1], 4'b0000} +: 16] = d[15:0];
    default: w = d;
  endcase
  return w;
endfunction

// Predicts the outputs one cycle after a strobe and updates the mirror
function automatic result_t predict(rv32i_pkg::instr_t ins, rv32i_pkg::word_t pc);
  result_t           r;
  logic [6:0]        op;
  logic [2:0]        f3;
  rv32i_pkg::word_t  a;
  rv32i_pkg::word_t  b;
  rv32i_pkg::word_t  imm_i;
  rv32i_pkg::word_t  imm_s;
  rv32i_pkg::word_t  imm_b;
  rv32i_pkg::word_t  imm_u;
  rv32i_pkg::word_t  imm_j;
  rv32i_pkg::word_t  addr;
  rv32i_pkg::word_t  val;
  logic [MEM_AW-1:0] wi;
  r = '0;
  val = '0;
  if (m_halted || ins == rv32i_pkg::HALT_INSTR) begin
    m_halted = 1'b1;
    r.halt = 1'b1;
    return r;
  end
  op = ins[6:0];
  f3 = ins[14:12];
  a = m_regs[ins[19:15]];
  b = m_regs[ins[24:20]];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_u = {ins[31:12], 12'b0};
  imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  addr = a + ((op == rv32i_pkg::STORE) ? imm_s : imm_i);
  wi = addr[MEM_AW+1:2];
  r.redir.valid = 1'b0;
  r.wb.valid = 1'b1;
  case (op)
    rv32i_pkg::REGREG: val = arith(f3, ins[30], 1'b1, a, b);
    rv32i_pkg::IMMED:  val = arith(f3, ins[30], 1'b0, a, imm_i);
    rv32i_pkg::LUI:    val = imm_u;
    rv32i_pkg::AUIPC:  val = pc + imm_u;
    rv32i_pkg::LOAD:   val = load_value(f3, m_mem[wi], addr[1:0]);
    rv32i_pkg::JAL: begin
      val = pc + 32'd4;
      r.redir = '{valid: 1'b1, target: pc + imm_j};
    end
    rv32i_pkg::JALR: begin
      val = pc + 32'd4;
      r.redir = '{valid: 1'b1, target: (a + imm_i) & ~32'd1};
    end
    rv32i_pkg::BRANCH: begin
      r.wb.valid = 1'b0;
      r.redir = '{valid: branch_cond(f3, a, b), target: pc + imm_b};
    end
    rv32i_pkg::STORE: begin
      r.wb.valid = 1'b0;
      m_mem[wi] = store_value(f3, m_mem[wi], b, addr[1:0]);
    end
    default: r.wb.valid = 1'b0;
  endcase
  if (r.wb.valid) begin
    r.wb.rd = ins[11:7];
    r.wb.data = val;
    if (ins[11:7] != 5'd0) begin
      m_regs[ins[11:7]] = val;
    end
  end
  return r;
endfunction

`endif

// ==== tb_rv32_exec.sv ====
// Testbench for the RV32I execute slice
// Presents directed and random instruction strobes to rv32_exec_core and
// compares writeback, redirect and halt one cycle later with the
// included reference model. Stops at the first mismatch
`default_nettype none

module tb_rv32_exec;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DMEM_WORDS   = 256;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int N_ARITH      = 400;
  localparam int N_CTRL       = 40;
  localparam int N_BRANCH     = 60;
  localparam int N_MEM        = 200;
  localparam int N_HALT       = 12;
  // Preload, memory init, read-backs, halt, second reset and drain
  localparam int N_FIXED      = 2 + 62 + 17 + N_CTRL / 4 + 3 + RESET_CYCLES + 6;
  localparam int N_TOTAL      = N_ARITH + N_CTRL + N_BRANCH + N_MEM + N_HALT + N_FIXED;
  localparam int TIMEOUT_NS   = (N_TOTAL + RESET_CYCLES + 100) * CLK_PERIOD;

  localparam logic [2:0] BR_CODES [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  localparam logic [2:0] LD_CODES [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

  logic                 CLK;
  logic                 reset_i;
  logic                 instr_valid_i;
  rv32i_pkg::instr_t    instr_i;
  rv32i_pkg::word_t     pc_i;
  rv32i_pkg::wb_t       wb_o;
  rv32i_pkg::redirect_t redirect_o;
  logic                 halt_o;

  `include "rv32_ref_model.svh"

  int unsigned cycle_count = 0;
  int unsigned due_q [$];
  result_t     exp_q [$];
  int          error_count = 0;

  rv32_exec_core #(
    .DMEM_WORDS (DMEM_WORDS)
  ) rv32_exec_core_i (
    .CLK           (CLK),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .wb_o          (wb_o),
    .redirect_o    (redirect_o),
    .halt_o        (halt_o)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  // Instruction encoders
  function automatic rv32i_pkg::instr_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic rv32i_pkg::instr_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv32i_pkg::instr_t enc_s(logic [11:0] imm, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv32i_pkg::STORE};
  endfunction

  function automatic rv32i_pkg::instr_t enc_b(logic [12:0] imm, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv32i_pkg::BRANCH};
  endfunction

  function automatic rv32i_pkg::instr_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv32i_pkg::instr_t enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32i_pkg::JAL};
  endfunction

  function automatic rv32i_pkg::reg_idx_t rand_reg();
    return 5'($urandom_range(31, 0));
  endfunction

  function automatic rv32i_pkg::word_t rand_pc();
    return $urandom() & 32'hffff_fffc;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      error_count++;
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, want);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // One strobe; the result is due after the next rising edge
  task automatic issue(input rv32i_pkg::instr_t ins, input rv32i_pkg::word_t pc);
    instr_valid_i = 1'b1;
    instr_i = ins;
    pc_i = pc;
    due_q.push_back(cycle_count + 1);
    exp_q.push_back(predict(ins, pc));
    @(negedge CLK);
    instr_valid_i = 1'b0;
  endtask

  task automatic idle();
    instr_valid_i = 1'b0;
    @(negedge CLK);
  endtask

  task automatic apply_reset();
    result_t cleared;
    cleared = '0;
    reset_i = 1'b1;
    instr_valid_i = 1'b0;
    for (int k = 1; k <= RESET_CYCLES; k++) begin
      due_q.push_back(cycle_count + k);
      exp_q.push_back(cleared);
    end
    model_reset();
    repeat (RESET_CYCLES) @(negedge CLK);
    reset_i = 1'b0;
  endtask

  // Outputs are checked on every falling edge; cycles without a strobe expect nothing
  initial begin : compare_outputs
    result_t want;
    logic    halted;
    halted = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    forever begin
      want = '0;
      want.halt = halted;
      if (due_q.size() > 0 && due_q[0] == cycle_count) begin
        void'(due_q.pop_front());
        want = exp_q.pop_front();
        halted = want.halt;
      end
      check("wb_o.valid", 64'(wb_o.valid), 64'(want.wb.valid));
      if (want.wb.valid) begin
        check("wb_o.rd", 64'(wb_o.rd), 64'(want.wb.rd));
        check("wb_o.data", 64'(wb_o.data), 64'(want.wb.data));
      end
      check("redirect_o.valid", 64'(redirect_o.valid), 64'(want.redir.valid));
      if (want.redir.valid) begin
        check("redirect_o.target", 64'(redirect_o.target), 64'(want.redir.target));
      end
      check("halt_o", 64'(halt_o), 64'(want.halt));
      @(negedge CLK);
    end
  end

  initial begin : stimulus
    rv32i_pkg::instr_t ins;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              alt;
    logic [11:0]       imm;
    logic [5:0]        off;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    void'($urandom(54831));
    reset_i = 1'b1;
    instr_valid_i = 1'b0;
    instr_i = '0;
    pc_i = '0;
    model_reset();
    repeat (RESET_CYCLES) @(negedge CLK);
    reset_i = 1'b0;

    // ADD x3, x1, x2 on cleared registers
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv32i_pkg::REGREG), 32'h0000_0100);
    idle();

    // Random register contents, then random arithmetic
    for (int r = 1; r < 32; r++) begin
      issue(enc_u(20'($urandom()), 5'(r), rv32i_pkg::LUI), rand_pc());
      issue(enc_i(12'($urandom()), 5'(r), 3'b000, 5'(r), rv32i_pkg::IMMED), rand_pc());
    end
    for (int n = 0; n < N_ARITH; n++) begin
      f3 = 3'($urandom());
      alt = 1'($urandom());
      rd = rand_reg();
      rs1 = rand_reg();
      rs2 = rand_reg();
      if (n % 2 == 0) begin
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        ins = enc_r(f7, rs2, rs1, f3, rd, rv32i_pkg::REGREG);
      end else begin
        imm = 12'($urandom());
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm[11:5] = (f3 == 3'b101 && alt) ? 7'h20 : 7'h00;
        end
        ins = enc_i(imm, rs1, f3, rd, rv32i_pkg::IMMED);
      end
      issue(ins, rand_pc());
    end

    // Upper immediates and jumps, some with rd x0
    for (int n = 0; n < N_CTRL; n++) begin
      rd = (n % 5 == 0) ? 5'd0 : rand_reg();
      rs1 = rand_reg();
      case (n % 4)
        0:       ins = enc_u(20'($urandom()), rd, rv32i_pkg::LUI);
        1:       ins = enc_u(20'($urandom()), rd, rv32i_pkg::AUIPC);
        2:       ins = enc_j(21'($urandom()), rd);
        default: ins = enc_i(12'($urandom()), rs1, 3'b000, rd, rv32i_pkg::JALR);
      endcase
      issue(ins, rand_pc());
      if (rd == 5'd0) begin
        // OR of x0 with itself reads back zero
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'b110, rand_reg(), rv32i_pkg::REGREG), rand_pc());
      end
    end

    // Branches, a quarter of them comparing a register with itself
    for (int n = 0; n < N_BRANCH; n++) begin
      rs1 = rand_reg();
      rs2 = ($urandom_range(3, 0) == 0) ? rs1 : rand_reg();
      issue(enc_b(13'($urandom()), rs2, rs1, BR_CODES[n % 6]), rand_pc());
    end

    // x10 holds the base of a 16-word region that is filled before use
    issue(enc_i(12'd256, 5'd0, 3'b000, 5'd10, rv32i_pkg::IMMED), rand_pc());
    for (int w = 0; w < 16; w++) begin
      issue(enc_s(12'(4 * w), rand_reg(), 5'd10, 3'b010), rand_pc());
    end
    for (int n = 0; n < N_MEM; n++) begin
      off = 6'($urandom());
      if ($urandom_range(1, 0) == 1) begin
        f3 = 3'($urandom_range(2, 0));
      end else begin
        f3 = LD_CODES[$urandom_range(4, 0)];
      end
      if (f3[1:0] == 2'b01) begin
        off[0] = 1'b0;
      end else if (f3[1:0] == 2'b10) begin
        off[1:0] = 2'b00;
      end
      if ($urandom_range(1, 0) == 1 && f3[2] == 1'b0) begin
        ins = enc_s({6'b0, off}, rand_reg(), 5'd10, f3);
      end else begin
        ins = enc_i({6'b0, off}, 5'd10, f3, 5'($urandom_range(31, 11)), rv32i_pkg::LOAD);
      end
      issue(ins, rand_pc());
    end

    // Halt, then strobes that must have no effect
    issue(rv32i_pkg::HALT_INSTR, rand_pc());
    idle();
    for (int n = 0; n < N_HALT; n++) begin
      if (n % 2 == 1) begin
        ins = enc_j(21'($urandom()), 5'd1);
      end else begin
        ins = enc_i(12'd5, 5'd0, 3'b000, 5'd1, rv32i_pkg::IMMED);
      end
      issue(ins, rand_pc());
    end
    idle();

    // Reset brings the slice back with cleared registers
    apply_reset();
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv32i_pkg::REGREG), 32'h0000_0200);
    issue(enc_i(12'd5, 5'd0, 3'b000, 5'd1, rv32i_pkg::IMMED), 32'h0000_0204);
    repeat (4) idle();

    if (error_count == 0 && due_q.size() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
